//--- files.f
+incdir+include
src/ctrl_pkg.sv
src/csr_pkg.sv
src/int_controller.sv
src/cs_registers.sv
src/mcycle_counter.sv
src/controller_fsm.sv
src/core_ctrl_top.sv
test/tb_clock_gen.sv
test/core_ctrl_assertions.sv
test/tb_core_ctrl.sv

//--- run.sh
#!/bin/sh
# Build the control slice testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_core_ctrl -f files.f -o sim_core_ctrl &&
./obj_dir/sim_core_ctrl | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- test/tb_core_ctrl.sv
/* Drives core_ctrl_top on the falling edge and samples it there too.
   Expected ids come from the irq and mie values chosen by the stimulus. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module tb_core_ctrl;

  // Status selectors for the wait loop
  localparam int sel_running = 0;
  localparam int sel_sleep   = 1;
  localparam int sel_halted  = 2;
  localparam int sel_ack     = 3;
  localparam int sel_no_rst  = 4;

  logic                   clk;
  logic                   rst;
  logic                   fetch_enable;
  logic [`XLEN-1:0]       irq;
  logic                   debug_req;
  logic                   wfi;
  logic                   csr_we;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  logic [`XLEN-1:0]       csr_wdata;
  logic                   irq_ack;
  logic [`IRQ_ID_W-1:0]   irq_id;
  logic                   havereset;
  logic                   running;
  logic                   halted;
  logic                   sleep;
  logic [`MCYCLE_W-1:0]   mcycle;

  integer seed;
  int     cyc = 0;
  int     err_count = 0;
  int     test_errs = 0;
  int     pass_tests = 0;
  int     fail_tests = 0;
  string  test_name = "none";

  // Expected acknowledge, set by the stimulus, consumed by the checker
  logic                 exp_valid = 1'b0;
  int                   exp_cyc = 0;
  logic [`IRQ_ID_W-1:0] exp_id = '0;

  tb_clock_gen clock_gen_i (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  core_ctrl_top dut (
    .clk_i             ( clk          ),
    .rst_i             ( rst          ),
    .fetch_enable_i    ( fetch_enable ),
    .irq_i             ( irq          ),
    .debug_req_i       ( debug_req    ),
    .wfi_i             ( wfi          ),
    .csr_we_i          ( csr_we       ),
    .csr_addr_i        ( csr_addr     ),
    .csr_wdata_i       ( csr_wdata    ),
    .irq_ack_o         ( irq_ack      ),
    .irq_id_o          ( irq_id       ),
    .debug_havereset_o ( havereset    ),
    .debug_running_o   ( running      ),
    .debug_halted_o    ( halted       ),
    .core_sleep_o      ( sleep        ),
    .mcycle_o          ( mcycle       )
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  // Highest index among pending lines enabled in mie
  function automatic logic [`IRQ_ID_W-1:0] expected_irq_id(logic [`XLEN-1:0] pend,
                                                          logic [`XLEN-1:0] en);
    logic [`XLEN-1:0]     masked;
    logic [`IRQ_ID_W-1:0] id;
    logic                 found;
    masked = pend & en;
    id     = '0;
    found  = 1'b0;
    for (int i = `XLEN - 1; i >= 0; i--) begin
      if (masked[i] && !found) begin
        id    = `IRQ_ID_W'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  function automatic logic status_bit(int sel);
    case (sel)
      sel_running: status_bit = running;
      sel_sleep:   status_bit = sleep;
      sel_halted:  status_bit = halted;
      sel_ack:     status_bit = irq_ack;
      default:     status_bit = !rst;
    endcase
  endfunction

  task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
    $display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    err_count++;
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(negedge clk);
  endtask

  // Polls one status bit on falling edges, gives up after limit cycles
  task automatic wait_status(int sel, string what, int limit);
    int n;
    n = 0;
    while (!status_bit(sel) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!status_bit(sel)) begin
      $display("timeout in %s: %s not seen within %0d cycles", test_name, what, limit);
      err_count++;
    end
  endtask

  // One-cycle write strobe, visible after the next edge
  task automatic csr_write(logic [`CSR_ADDR_W-1:0] addr, logic [`XLEN-1:0] data);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_we    = 1'b0;
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic finish_test();
    if (err_count == test_errs) begin
      pass_tests++;
      $display("test %s: passed", test_name);
    end else begin
      fail_tests++;
      $display("test %s: failed with %0d errors", test_name, err_count - test_errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Acknowledge checker
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Any ack without an expectation is an error, so masking tests rely on it
  always @(negedge clk) begin
    if (!rst) begin
      if (irq_ack) begin
        if (!exp_valid) begin
          $display("unexpected interrupt acknowledge in %s, id %0d", test_name, irq_id);
          err_count++;
        end else begin
          if (cyc != exp_cyc) report_mismatch("ack cycle", 64'(exp_cyc), 64'(cyc));
          if (irq_id !== exp_id) report_mismatch("irq_id", 64'(exp_id), 64'(irq_id));
        end
      end else if (exp_valid && cyc == exp_cyc) begin
        report_mismatch("irq_ack", 64'd1, 64'd0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [`XLEN-1:0]     irq_val;
    logic [`XLEN-1:0]     mie_val;
    logic [`MCYCLE_W-1:0] mcycle_ref;
    seed         = 32'h7875e24c;
    fetch_enable = 1'b0;
    irq          = '0;
    debug_req    = 1'b0;
    wfi          = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    @(negedge clk);

    // Boot wait, then K running cycles
    start_test("boot");
    wait_status(sel_no_rst, "reset release", 40);
    if (irq_ack || running || halted || sleep) begin
      report_mismatch("idle outputs", 64'd0, 64'({irq_ack, running, halted, sleep}));
    end
    if (havereset !== 1'b1) report_mismatch("havereset", 64'd1, 64'(havereset));
    if (mcycle !== '0) report_mismatch("mcycle at reset", 64'd0, mcycle);
    wait_cycles(5);
    if (mcycle !== '0) report_mismatch("mcycle before fetch", 64'd0, mcycle);
    fetch_enable = 1'b1;
    wait_status(sel_running, "debug_running_o", 10);
    mcycle_ref = mcycle;
    wait_cycles(8);
    if (mcycle - mcycle_ref != 64'd8) report_mismatch("mcycle delta", 64'd8, mcycle - mcycle_ref);
    finish_test();

    // Random irq and mie pairs, ack two cycles after the sampling edge
    start_test("irq_priority");
    for (int n = 0; n < 20; n++) begin
      irq_val = $random(seed);
      mie_val = $random(seed);
      if ((irq_val & mie_val) == '0) begin
        irq_val[0] = 1'b1;
        mie_val[0] = 1'b1;
      end
      csr_write(csr_pkg::MIE, mie_val);
      csr_write(csr_pkg::MSTATUS, 32'h8);
      irq       = irq_val;
      exp_id    <= expected_irq_id(irq_val, mie_val);
      exp_cyc   <= cyc + 3;
      exp_valid <= 1'b1;
      wait_status(sel_ack, "irq_ack_o", 10);
      exp_valid <= 1'b0;
      irq       = '0;
    end
    finish_test();

    start_test("masking");
    // Line 5 pending but off in mie
    csr_write(csr_pkg::MIE, 32'hffff_ffdf);
    csr_write(csr_pkg::MSTATUS, 32'h8);
    irq = 32'h20;
    wait_cycles(10);
    irq = '0;
    // Line 9 on in mie, global enable clear
    csr_write(csr_pkg::MIE, 32'h200);
    csr_write(csr_pkg::MSTATUS, 32'h0);
    irq = 32'h200;
    wait_cycles(10);
    // Line held, each MIE rewrite allows exactly one trap
    repeat (2) begin
      exp_id    <= 5'd9;
      exp_cyc   <= cyc + 3;
      exp_valid <= 1'b1;
      csr_write(csr_pkg::MSTATUS, 32'h8);
      wait_status(sel_ack, "irq_ack_o", 10);
      exp_valid <= 1'b0;
      wait_cycles(10);
    end
    irq = '0;
    finish_test();

    // Wake-up through mie alone, MIE still clear after the last trap
    start_test("sleep");
    csr_write(csr_pkg::MIE, 32'h80);
    wfi = 1'b1;
    @(negedge clk);
    wfi = 1'b0;
    wait_status(sel_sleep, "core_sleep_o", 10);
    if (running !== 1'b0) report_mismatch("running in sleep", 64'd0, 64'(running));
    mcycle_ref = mcycle;
    wait_cycles(5);
    if (mcycle !== mcycle_ref) report_mismatch("mcycle in sleep", mcycle_ref, mcycle);
    irq = 32'h80;
    wait_status(sel_running, "debug_running_o", 10);
    if (sleep !== 1'b0) report_mismatch("sleep after wake", 64'd0, 64'(sleep));
    mcycle_ref = mcycle;
    wait_cycles(10);
    if (mcycle - mcycle_ref != 64'd10) report_mismatch("mcycle after wake", 64'd10,
                                                        mcycle - mcycle_ref);
    irq = '0;
    finish_test();

    start_test("debug");
    if (havereset !== 1'b1) report_mismatch("havereset before halt", 64'd1, 64'(havereset));
    debug_req = 1'b1;
    wait_status(sel_halted, "debug_halted_o", 10);
    if (running !== 1'b0) report_mismatch("running in halt", 64'd0, 64'(running));
    if (havereset !== 1'b0) report_mismatch("havereset in halt", 64'd0, 64'(havereset));
    mcycle_ref = mcycle;
    wait_cycles(5);
    if (mcycle !== mcycle_ref) report_mismatch("mcycle in halt", mcycle_ref, mcycle);
    debug_req = 1'b0;
    wait_status(sel_running, "debug_running_o", 10);
    if (halted !== 1'b0) report_mismatch("halted after resume", 64'd0, 64'(halted));
    // Debug and an enabled interrupt on the same edge, debug wins
    // Line 3 and MIE land in mip and mstatus on one edge, debug is seen on the next
    csr_write(csr_pkg::MIE, 32'h8);
    irq = 32'h8;
    csr_write(csr_pkg::MSTATUS, 32'h8);
    debug_req = 1'b1;
    wait_status(sel_halted, "debug_halted_o", 10);
    wait_cycles(10);
    irq = '0;
    csr_write(csr_pkg::MSTATUS, 32'h0);
    debug_req = 1'b0;
    wait_status(sel_running, "debug_running_o", 10);
    if (havereset !== 1'b0) report_mismatch("havereset after resume", 64'd0, 64'(havereset));
    finish_test();

    $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
             pass_tests, fail_tests, err_count, dut.controller_fsm_i.assertions_i.fail_count);
    if (err_count == 0 && fail_tests == 0 &&
        dut.controller_fsm_i.assertions_i.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- test/core_ctrl_assertions.sv
/* Checks on the controller status struct, bound into every controller_fsm.
   Disabled while reset is high. */

`timescale 1ns/1ps

module core_ctrl_assertions (
  input logic                clk_i,
  input logic                rst_i,
  input ctrl_pkg::ctrl_fsm_t ctrl_fsm_i
);

  // Failures so far, read by the testbench top
  int fail_count = 0;

  // Trap entry is a single-cycle pulse
  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_fsm_i.irq_ack |=> !ctrl_fsm_i.irq_ack)
    else begin
      fail_count++;
      $error("irq_ack high two cycles in a row");
    end

  // Halted and running exclude each other
  halt_run_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ctrl_fsm_i.halted && ctrl_fsm_i.running))
    else begin
      fail_count++;
      $error("halted and running high together");
    end

  // No sleep while in debug halt
  sleep_halt_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ctrl_fsm_i.sleep && ctrl_fsm_i.halted))
    else begin
      fail_count++;
      $error("sleep and halted high together");
    end

endmodule

bind controller_fsm core_ctrl_assertions assertions_i (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .ctrl_fsm_i ( ctrl_fsm_o )
);

//--- test/tb_clock_gen.sv
/* Free running 4 ns clock and a reset held for the first 16 rising edges.
   Reset is released with a nonblocking update right after an edge. */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    // 16 edges seen with reset high
    repeat (16) @(posedge clk_o);
    rst_o <= 1'b0;
  end

  // Half period 2 ns
  always #2 clk_o = ~clk_o;

endmodule

//--- src/core_ctrl_top.sv
/* Control slice of the core: no pipeline, no buses, no CLIC.
   CSR writes come from a plain strobe port, WFI from a strobe input. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module core_ctrl_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   fetch_enable_i,
  input  logic [`XLEN-1:0]       irq_i,
  input  logic                   debug_req_i,
  input  logic                   wfi_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`XLEN-1:0]       csr_wdata_i,
  output logic                   irq_ack_o,
  output logic [`IRQ_ID_W-1:0]   irq_id_o,
  output logic                   debug_havereset_o,
  output logic                   debug_running_o,
  output logic                   debug_halted_o,
  output logic                   core_sleep_o,
  output logic [`MCYCLE_W-1:0]   mcycle_o
);

  ctrl_pkg::ctrl_fsm_t  ctrl_fsm;
  logic                 count_en;

  // Interrupt controller to FSM
  logic                 irq_req;
  logic                 irq_wu;
  logic [`IRQ_ID_W-1:0] irq_id;

  // CSRs to interrupt controller
  logic [`XLEN-1:0]     mie;
  logic                 m_irq_enable;

  // Status outputs from the FSM struct
  assign irq_ack_o         = ctrl_fsm.irq_ack;
  assign irq_id_o          = ctrl_fsm.irq_id;
  assign debug_havereset_o = ctrl_fsm.havereset;
  assign debug_running_o   = ctrl_fsm.running;
  assign debug_halted_o    = ctrl_fsm.halted;
  assign core_sleep_o      = ctrl_fsm.sleep;

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  controller_fsm controller_fsm_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .wfi_i          ( wfi_i          ),
    .irq_req_i      ( irq_req        ),
    .irq_wu_i       ( irq_wu         ),
    .irq_id_i       ( irq_id         ),
    .ctrl_fsm_o     ( ctrl_fsm       ),
    .count_en_o     ( count_en       )
  );

  //////////////////////////////////////////////////////////////////////
  // Interrupts and CSRs
  //////////////////////////////////////////////////////////////////////

  int_controller int_controller_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .irq_i          ( irq_i          ),
    .mie_i          ( mie            ),
    .m_irq_enable_i ( m_irq_enable   ),
    .irq_req_o      ( irq_req        ),
    .irq_wu_o       ( irq_wu         ),
    .irq_id_o       ( irq_id         )
  );

  cs_registers cs_registers_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .csr_we_i       ( csr_we_i       ),
    .csr_addr_i     ( csr_addr_i     ),
    .csr_wdata_i    ( csr_wdata_i    ),
    .ctrl_fsm_i     ( ctrl_fsm       ),
    .mie_o          ( mie            ),
    .m_irq_enable_o ( m_irq_enable   )
  );

  // Cycle count, RUN state only
  mcycle_counter mcycle_counter_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .count_en_i     ( count_en       ),
    .mcycle_o       ( mcycle_o       )
  );

endmodule

//--- src/controller_fsm.sv
/* Control FSM: boot, run, sleep, debug halt and interrupt acknowledge.
   Priority on each edge is debug, then interrupt, then WFI.
   An interrupt is acknowledged two edges after the pick is seen. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module controller_fsm (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 fetch_enable_i,
  input  logic                 debug_req_i,
  input  logic                 wfi_i,
  input  logic                 irq_req_i,
  input  logic                 irq_wu_i,
  input  logic [`IRQ_ID_W-1:0] irq_id_i,
  output ctrl_pkg::ctrl_fsm_t  ctrl_fsm_o,
  output logic                 count_en_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  logic                 havereset_q;
  logic                 irq_take;
  logic                 irq_taken_q;  // Interrupt accepted, ack next edge
  logic                 irq_ack_q;
  logic [`IRQ_ID_W-1:0] irq_id_q;

  // Accept only in RUN, not under debug, one trap in flight at most
  assign irq_take = (state_q == ctrl_pkg::RUN) && irq_req_i && !debug_req_i &&
                    !irq_taken_q && !irq_ack_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::RESET: begin
        state_d = ctrl_pkg::BOOT_WAIT;
      end
      ctrl_pkg::BOOT_WAIT: begin
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::RUN;
        end
      end
      ctrl_pkg::RUN: begin
        // WFI loses against a pending trap
        if (debug_req_i) begin
          state_d = ctrl_pkg::DEBUG_HALT;
        end else if (wfi_i && !irq_take && !irq_taken_q) begin
          state_d = ctrl_pkg::SLEEP;
        end
      end
      ctrl_pkg::SLEEP: begin
        if (debug_req_i) begin
          state_d = ctrl_pkg::DEBUG_HALT;
        end else if (irq_wu_i) begin
          state_d = ctrl_pkg::RUN;
        end
      end
      ctrl_pkg::DEBUG_HALT: begin
        if (!debug_req_i) begin
          state_d = ctrl_pkg::RUN;
        end
      end
      default: begin
        state_d = ctrl_pkg::RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and status registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ctrl_pkg::RESET;
      havereset_q <= 1'b1;
      irq_taken_q <= 1'b0;
      irq_ack_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      irq_taken_q <= irq_take;
      // Late debug request drops the trap
      irq_ack_q   <= irq_taken_q && !debug_req_i;
      // Cleared for good by the first halt
      if (state_d == ctrl_pkg::DEBUG_HALT) begin
        havereset_q <= 1'b0;
      end
    end
  end

  // Id captured with the decision
  always_ff @(posedge clk_i) begin
    if (irq_take) begin
      irq_id_q <= irq_id_i;
    end
  end

  // Status straight from the state register
  always_comb begin
    ctrl_fsm_o.running   = (state_q == ctrl_pkg::RUN);
    ctrl_fsm_o.halted    = (state_q == ctrl_pkg::DEBUG_HALT);
    ctrl_fsm_o.havereset = havereset_q;
    ctrl_fsm_o.sleep     = (state_q == ctrl_pkg::SLEEP);
    ctrl_fsm_o.irq_ack   = irq_ack_q;
    ctrl_fsm_o.irq_id    = irq_id_q;
  end

  assign count_en_o = (state_q == ctrl_pkg::RUN);

endmodule

//--- src/mcycle_counter.sv
/* 64-bit mcycle, counts only while enabled.
   Not writable by software. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module mcycle_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 count_en_i,
  output logic [`MCYCLE_W-1:0] mcycle_o
);

  logic [`MCYCLE_W-1:0] mcycle_q;

  // Frozen in boot wait, sleep and debug halt
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else if (count_en_i) begin
      mcycle_q <= mcycle_q + `MCYCLE_W'(1);
    end
  end

  assign mcycle_o = mcycle_q;

endmodule

//--- src/cs_registers.sv
/* Interrupt CSRs only: mie and mstatus.MIE, write-only port, no read mux.
   Trap entry wins over a software write to mstatus in the same cycle. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module cs_registers (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`XLEN-1:0]      csr_wdata_i,
  input  ctrl_pkg::ctrl_fsm_t   ctrl_fsm_i,
  output logic [`XLEN-1:0]      mie_o,
  output logic                  m_irq_enable_o
);

  logic [`XLEN-1:0]  mie_q;
  csr_pkg::mstatus_t mstatus_q;
  csr_pkg::mstatus_t wdata_mstatus;

  // Write data seen through the mstatus layout
  assign wdata_mstatus = csr_pkg::mstatus_t'(csr_wdata_i);

  //////////////////////////////////////////////////////////////////////
  // CSR update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q     <= '0;
      mstatus_q <= '0;
    end else begin
      // mie is untouched by trap entry
      if (csr_we_i && (csr_addr_i == csr_pkg::MIE)) begin
        mie_q <= csr_wdata_i;
      end
      // Trap entry clears the global enable
      if (ctrl_fsm_i.irq_ack) begin
        mstatus_q.mie <= 1'b0;
      end else if (csr_we_i && (csr_addr_i == csr_pkg::MSTATUS)) begin
        // Only MIE is writable
        mstatus_q.mie <= wdata_mstatus.mie;
      end
    end
  end

  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

//--- src/int_controller.sv
/* Basic mode interrupt controller, no CLIC and no NMI.
   Fixed priority: the highest line index wins. */

`timescale 1ns/1ps
`include "core_ctrl_defines.svh"

module int_controller (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`XLEN-1:0]     irq_i,
  input  logic [`XLEN-1:0]     mie_i,
  input  logic                 m_irq_enable_i,
  output logic                 irq_req_o,
  output logic                 irq_wu_o,
  output logic [`IRQ_ID_W-1:0] irq_id_o
);

  logic [`XLEN-1:0] mip_q;
  logic [`XLEN-1:0] irq_pend;

  // Sample raw lines into mip
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i;
    end
  end

  // Locally enabled lines
  assign irq_pend = mip_q & mie_i;

  // Wake-up ignores mstatus.MIE
  assign irq_wu_o  = |irq_pend;
  assign irq_req_o = irq_wu_o & m_irq_enable_i;

  // Last set bit overrides, so the highest index wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `XLEN; i++) begin
      if (irq_pend[i]) begin
        irq_id_o = `IRQ_ID_W'(i);
      end
    end
  end

endmodule

//--- src/csr_pkg.sv
/* Machine CSR addresses and the mstatus layout.
   Only mstatus.MIE is implemented, all other fields read as zero. */

`include "core_ctrl_defines.svh"

package csr_pkg;

  // Supported CSR addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    MSTATUS = 12'h300,
    MIE     = 12'h304
  } csr_addr_e;

  // Full RV32 mstatus layout, MSB first
  typedef struct packed {
    logic       sd;
    logic [7:0] wpri_30_23;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] mpp;
    logic [1:0] vs;
    logic       spp;
    logic       mpie;
    logic       ube;
    logic       spie;
    logic       wpri_4;
    logic       mie;      // Global machine interrupt enable, bit 3
    logic       wpri_2;
    logic       sie;
    logic       wpri_0;
  } mstatus_t;

endpackage

//--- src/ctrl_pkg.sv
/* Controller state encoding and the struct it broadcasts to the core.
   Only five of the eight state codes are used. */

`include "core_ctrl_defines.svh"

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    RESET      = 3'd0,
    BOOT_WAIT  = 3'd1,
    RUN        = 3'd2,
    SLEEP      = 3'd3,
    DEBUG_HALT = 3'd4
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // Controller outputs, 10 bits
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 running;    // Executing, not halted or asleep
    logic                 halted;     // In debug halt
    logic                 havereset;  // Reset seen, no halt since
    logic                 sleep;      // Waiting for interrupt
    logic                 irq_ack;    // One-cycle trap entry pulse
    logic [`IRQ_ID_W-1:0] irq_id;     // Valid with irq_ack
  } ctrl_fsm_t;

endpackage

//--- include/core_ctrl_defines.svh
/* Widths shared by the control slice and its testbench.
   XLEN and MCYCLE_W are fixed by the RV32 machine CSRs, do not change them. */

`ifndef CORE_CTRL_DEFINES_SVH
`define CORE_CTRL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Datapath and CSR widths
//////////////////////////////////////////////////////////////////////

// Data word, also the number of irq lines
`define XLEN 32

// Index of one irq line, log2 of XLEN
`define IRQ_ID_W 5

// Standard CSR address field
`define CSR_ADDR_W 12

// mcycle plus mcycleh
`define MCYCLE_W 64

`endif
